// ==== id_stage.f ====
src/id_pkg.sv
src/id_decoder.sv
src/id_register_file.sv
src/id_operand_mux.sv
src/id_multicycle_fsm.sv
src/id_stage.sv
verification/id_stage_properties.sv
verification/tb_id_stage.sv

// ==== run.sh ====
#!/bin/sh
# Build the decode stage testbench with Verilator and run it
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_id_stage -f id_stage.f -o tb_id_stage &&
  ./obj_dir/tb_id_stage ||
  exit 1

// ==== verification/tb_id_stage.sv ====
////////////////////////////////////////
// Decode stage testbench
////////////////////////////////////////

`timescale 1ns/1ns

module tb_id_stage;

  localparam int TIMEOUT = 20;
  localparam int N_INSTR = 300;

  logic              clk_i = 1'b0;
  logic              rst_ni;
  id_pkg::fetch_t    fetch_i;
  logic              instr_new_i;
  logic              branch_decision_i;
  logic              ex_valid_i;
  logic              lsu_valid_i;
  logic              lsu_load_err_i;
  id_pkg::word_t     regfile_wdata_ex_i;
  id_pkg::word_t     regfile_wdata_lsu_i;
  id_pkg::ex_req_t   ex_req_o;
  id_pkg::lsu_req_t  lsu_req_o;
  logic              id_ready_o;
  logic              pc_set_o;
  logic              instr_ret_o;
  logic              illegal_insn_o;

  // Expected register contents and fetch PC
  id_pkg::word_t     ref_regs [32];
  id_pkg::word_t     pc;
  logic [31:0]       lfsr = 32'h5c02;

  id_stage uut (.*);

  always #2 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Helpers
  function automatic id_pkg::word_t take_bits(input int n);
    id_pkg::word_t v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic id_pkg::word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic id_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'b001:  return id_pkg::ALU_SLL;
      3'b010:  return id_pkg::ALU_SLT;
      3'b011:  return id_pkg::ALU_SLTU;
      3'b100:  return id_pkg::ALU_XOR;
      3'b101:  return alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'b110:  return id_pkg::ALU_OR;
      default: return id_pkg::ALU_AND;
    endcase
  endfunction

  function automatic id_pkg::alu_op_e branch_op(input logic [2:0] f3);
    case (f3)
      3'b000:  return id_pkg::ALU_EQ;
      3'b001:  return id_pkg::ALU_NE;
      3'b100:  return id_pkg::ALU_LT;
      3'b101:  return id_pkg::ALU_GE;
      3'b110:  return id_pkg::ALU_LTU;
      default: return id_pkg::ALU_GEU;
    endcase
  endfunction

  // S and B share one field layout, as do U and J
  function automatic id_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic id_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic id_pkg::word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [6:0] opc);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
  endfunction

  function automatic id_pkg::word_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input id_pkg::word_t got,
                            input id_pkg::word_t exp);
    assert (got == exp) else begin
      $display("error %s expected %08h got %08h", name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got == exp) else begin
      $display("error %s expected %0h got %0h", name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_req(input id_pkg::alu_op_e op, input id_pkg::word_t a,
                           input id_pkg::word_t b);
    check_bit("illegal_insn_o", illegal_insn_o, 1'b0);
    check_word("ex_req_o.alu_op", {27'b0, ex_req_o.alu_op}, {27'b0, op});
    check_word("ex_req_o.operand_a", ex_req_o.operand_a, a);
    check_word("ex_req_o.operand_b", ex_req_o.operand_b, b);
  endtask

  ////////////////////////////////////////
  // Cycle level driving
  task automatic tick();
    @(posedge clk_i);
    #1;
  endtask

  task automatic start(input id_pkg::word_t instr, input logic taken);
    tick();
    pc                 = pc + 32'd4;
    fetch_i.instr      = instr;
    fetch_i.pc         = pc;
    instr_new_i        = 1'b1;
    branch_decision_i  = taken;
    ex_valid_i         = 1'b0;
    lsu_valid_i        = 1'b0;
    lsu_load_err_i     = 1'b0;
    regfile_wdata_ex_i = take_bits(32);
    #2;
  endtask

  task automatic quiet_cycle();
    tick();
    instr_new_i       = 1'b0;
    branch_decision_i = 1'b0;
    #2;
  endtask

  task automatic retire_now(input id_pkg::reg_addr_t rd);
    check_bit("instr_ret_o", instr_ret_o, 1'b1);
    check_bit("id_ready_o", id_ready_o, 1'b1);
    check_bit("pc_set_o", pc_set_o, 1'b0);
    check_bit("lsu_req_o.req", lsu_req_o.req, 1'b0);
    if (rd != 5'd0) begin
      ref_regs[rd] = regfile_wdata_ex_i;
    end
  endtask

  // EX or LSU answers after a random number of cycles
  task automatic answer_late(input logic use_lsu);
    int delay;
    int cnt;
    delay = int'(take_bits(2));
    for (int k = 0; k < delay; k++) begin
      tick();
      #2;
      check_bit("id_ready_o", id_ready_o, 1'b0);
      check_bit("pc_set_o", pc_set_o, 1'b0);
      check_bit("instr_ret_o", instr_ret_o, 1'b0);
      if (use_lsu) begin
        check_bit("lsu_req_o.req", lsu_req_o.req, 1'b1);
      end
    end
    tick();
    regfile_wdata_ex_i  = take_bits(32);
    regfile_wdata_lsu_i = take_bits(32);
    if (use_lsu) begin
      lsu_valid_i    = 1'b1;
      lsu_load_err_i = 1'(take_bits(1));
    end else begin
      ex_valid_i = 1'b1;
    end
    #2;
    cnt = 0;
    while (!id_ready_o) begin
      if (cnt == TIMEOUT) begin
        $display("timeout: id_ready_o never rose after the unit answered");
        abort_run();
      end
      @(posedge clk_i);
      #3;
      cnt++;
    end
    check_bit("instr_ret_o", instr_ret_o, 1'b1);
  endtask

  ////////////////////////////////////////
  // One random instruction
  task automatic run_one();
    logic [3:0]        kind;
    logic [2:0]        f3;
    logic              alt;
    logic [11:0]       imm12;
    logic [19:0]       imm20;
    id_pkg::reg_addr_t rs1;
    id_pkg::reg_addr_t rs2;
    id_pkg::reg_addr_t rd;
    id_pkg::word_t     a;
    id_pkg::word_t     b;
    kind  = 4'(take_bits(4));
    f3    = 3'(take_bits(3));
    alt   = 1'(take_bits(1));
    imm12 = 12'(take_bits(12));
    imm20 = 20'(take_bits(20));
    rs1   = 5'(take_bits(5));
    rs2   = 5'(take_bits(5));
    rd    = 5'(take_bits(5));
    a     = ref_regs[rs1];
    b     = ref_regs[rs2];
    case (kind)
      4'd2, 4'd3: begin
        alt = alt & (f3 == 3'b000 || f3 == 3'b101);
        start(enc_r({1'b0, alt, 5'b0}, rs2, rs1, f3, rd, id_pkg::OPC_OP), 1'b0);
        check_req(arith_op(f3, alt), a, b);
        retire_now(rd);
      end
      4'd4: begin
        start(enc_u(imm20, rd, id_pkg::OPC_LUI), 1'b0);
        check_req(id_pkg::ALU_ADD, '0, {imm20, 12'b0});
        retire_now(rd);
      end
      4'd5: begin
        start(enc_u(imm20, rd, id_pkg::OPC_AUIPC), 1'b0);
        check_req(id_pkg::ALU_ADD, pc, {imm20, 12'b0});
        retire_now(rd);
      end
      4'd6, 4'd7: begin
        if (f3[1:0] == 2'b11 || f3 == 3'b110) begin
          f3 = 3'b010;
        end
        start(enc_i(imm12, rs1, f3, rd, id_pkg::OPC_LOAD), 1'b0);
        check_req(id_pkg::ALU_ADD, a, sext12(imm12));
        check_bit("lsu_req_o.req", lsu_req_o.req, 1'b1);
        check_bit("lsu_req_o.we", lsu_req_o.we, 1'b0);
        check_word("lsu_req_o.size", {30'b0, lsu_req_o.size}, {30'b0, f3[1:0]});
        check_bit("lsu_req_o.sign_ext", lsu_req_o.sign_ext, ~f3[2]);
        check_bit("instr_ret_o", instr_ret_o, 1'b0);
        quiet_cycle();
        check_bit("id_ready_o", id_ready_o, 1'b0);
        answer_late(1'b1);
        if (!lsu_load_err_i && rd != 5'd0) begin
          ref_regs[rd] = regfile_wdata_lsu_i;
        end
      end
      4'd8: begin
        f3 = (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]};
        start(enc_s(imm12, rs2, rs1, f3, id_pkg::OPC_STORE), 1'b0);
        check_req(id_pkg::ALU_ADD, a, sext12(imm12));
        check_bit("lsu_req_o.req", lsu_req_o.req, 1'b1);
        check_bit("lsu_req_o.we", lsu_req_o.we, 1'b1);
        check_word("lsu_req_o.wdata", lsu_req_o.wdata, b);
        check_word("lsu_req_o.size", {30'b0, lsu_req_o.size}, {30'b0, f3[1:0]});
        quiet_cycle();
        check_bit("id_ready_o", id_ready_o, 1'b0);
        answer_late(1'b1);
      end
      4'd9, 4'd10: begin
        if (f3[2:1] == 2'b01) begin
          f3[2:1] = 2'b10;
        end
        start(enc_s(imm12, rs2, rs1, f3, id_pkg::OPC_BRANCH), alt);
        check_req(branch_op(f3), a, b);
        check_bit("pc_set_o", pc_set_o, 1'b0);
        check_bit("instr_ret_o", instr_ret_o, ~alt);
        check_bit("id_ready_o", id_ready_o, ~alt);
        quiet_cycle();
        check_bit("pc_set_o", pc_set_o, alt);
        if (alt) begin
          answer_late(1'b0);
        end
      end
      4'd11: begin
        start(enc_u(imm20, rd, id_pkg::OPC_JAL), 1'b0);
        check_req(id_pkg::ALU_ADD, pc, id_pkg::PC_INCR);
        check_bit("pc_set_o", pc_set_o, 1'b1);
        check_bit("id_ready_o", id_ready_o, 1'b0);
        quiet_cycle();
        check_bit("pc_set_o", pc_set_o, 1'b0);
        answer_late(1'b0);
        if (rd != 5'd0) begin
          ref_regs[rd] = regfile_wdata_ex_i;
        end
      end
      4'd12, 4'd13: begin
        if (kind[0]) begin
          // Memory access with an unsupported size
          if (alt) begin
            start(enc_s(imm12, rs2, rs1, {1'b1, f3[1:0]}, id_pkg::OPC_STORE), 1'b0);
          end else begin
            start(enc_i(imm12, rs1, {f3[2], 2'b11}, rd, id_pkg::OPC_LOAD), 1'b0);
          end
        end else begin
          // Opcode zero or JALR is not supported
          start(enc_i(imm12, rs1, f3, rd, alt ? 7'h67 : 7'h00), 1'b0);
        end
        check_bit("illegal_insn_o", illegal_insn_o, 1'b1);
        check_bit("lsu_req_o.req", lsu_req_o.req, 1'b0);
        check_bit("instr_ret_o", instr_ret_o, 1'b0);
        check_bit("id_ready_o", id_ready_o, 1'b1);
      end
      default: begin
        alt = alt & (f3 == 3'b101);
        if (f3[1:0] == 2'b01) begin
          imm12 = {1'b0, alt, 5'b0, imm12[4:0]};
        end
        start(enc_i(imm12, rs1, f3, rd, id_pkg::OPC_OP_IMM), 1'b0);
        check_req(arith_op(f3, alt), a, sext12(imm12));
        retire_now(rd);
      end
    endcase
  endtask

  ////////////////////////////////////////
  // Main sequence
  initial begin
    rst_ni              = 1'b0;
    fetch_i             = '0;
    instr_new_i         = 1'b0;
    branch_decision_i   = 1'b0;
    ex_valid_i          = 1'b0;
    lsu_valid_i         = 1'b0;
    lsu_load_err_i      = 1'b0;
    regfile_wdata_ex_i  = '0;
    regfile_wdata_lsu_i = '0;
    pc                  = 32'h0000_1000;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    #2;
    check_bit("id_ready_o", id_ready_o, 1'b1);
    check_bit("pc_set_o", pc_set_o, 1'b0);
    check_bit("instr_ret_o", instr_ret_o, 1'b0);
    check_bit("lsu_req_o.req", lsu_req_o.req, 1'b0);

    for (int n = 0; n < N_INSTR; n++) begin
      run_one();
    end

    // Read back every register through operand A
    for (int r = 1; r < 32; r++) begin
      start(enc_i(12'h000, 5'(r), 3'b000, 5'd0, id_pkg::OPC_OP_IMM), 1'b0);
      check_req(id_pkg::ALU_ADD, ref_regs[r], '0);
      retire_now(5'd0);
    end
    quiet_cycle();
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== verification/id_stage_properties.sv ====
////////////////////////////////////////
// Decode stage port properties
////////////////////////////////////////

`timescale 1ns/1ns

module id_stage_properties (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             instr_new_i,
  input logic             lsu_valid_i,
  input id_pkg::lsu_req_t lsu_req_i,
  input logic             id_ready_i,
  input logic             pc_set_i,
  input logic             instr_ret_i,
  input logic             illegal_insn_i
);

  // Nothing redirects or retires in reset
  reset_quiet_a: assert property (
    @(posedge clk_i) !rst_ni |-> (!pc_set_i && !instr_ret_i)
  ) else $error("pc_set_o or instr_ret_o high while in reset");

  // A pending memory access holds the stage
  lsu_stall_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (lsu_req_i.req && !instr_new_i && !lsu_valid_i) |-> !id_ready_i
  ) else $error("id_ready_o high while a memory access is pending");

  illegal_no_lsu_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    illegal_insn_i |-> !lsu_req_i.req
  ) else $error("memory request raised for an illegal instruction");

  // Redirect is a single cycle pulse
  pc_set_pulse_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |=> !pc_set_i
  ) else $error("pc_set_o high on two consecutive cycles");

endmodule

bind id_stage id_stage_properties u_properties (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .instr_new_i    (instr_new_i),
  .lsu_valid_i    (lsu_valid_i),
  .lsu_req_i      (lsu_req_o),
  .id_ready_i     (id_ready_o),
  .pc_set_i       (pc_set_o),
  .instr_ret_i    (instr_ret_o),
  .illegal_insn_i (illegal_insn_o)
);

// ==== src/id_stage.sv ====
////////////////////////////////////////
// RV32I decode stage
////////////////////////////////////////

`timescale 1ns/1ns

module id_stage (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  id_pkg::fetch_t   fetch_i,
  input  logic             instr_new_i,
  input  logic             branch_decision_i,
  input  logic             ex_valid_i,
  input  logic             lsu_valid_i,
  input  logic             lsu_load_err_i,
  input  id_pkg::word_t    regfile_wdata_ex_i,
  input  id_pkg::word_t    regfile_wdata_lsu_i,
  output id_pkg::ex_req_t  ex_req_o,
  output id_pkg::lsu_req_t lsu_req_o,
  output logic             id_ready_o,
  output logic             pc_set_o,
  output logic             instr_ret_o,
  output logic             illegal_insn_o
);

  id_pkg::dec_ctrl_t ctrl;
  id_pkg::imm_set_t  imm;
  id_pkg::word_t     rdata_a;
  id_pkg::word_t     rdata_b;
  id_pkg::word_t     regfile_wdata;
  logic              regfile_we;
  logic              executing;

  id_decoder u_decoder (
    .instr_i (fetch_i.instr),
    .ctrl_o  (ctrl),
    .imm_o   (imm)
  );

  // Write-back source
  assign regfile_wdata = (ctrl.rf_wd_sel == id_pkg::RF_WD_LSU) ? regfile_wdata_lsu_i
                                                               : regfile_wdata_ex_i;

  id_register_file u_register_file (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (ctrl.raddr_a),
    .rdata_a_o (rdata_a),
    .raddr_b_i (ctrl.raddr_b),
    .rdata_b_o (rdata_b),
    .waddr_i   (ctrl.waddr),
    .wdata_i   (regfile_wdata),
    .we_i      (regfile_we)
  );

  id_operand_mux u_operand_mux (
    .ctrl_i      (ctrl),
    .imm_i       (imm),
    .pc_i        (fetch_i.pc),
    .rdata_a_i   (rdata_a),
    .rdata_b_i   (rdata_b),
    .executing_i (executing),
    .ex_req_o    (ex_req_o),
    .lsu_req_o   (lsu_req_o)
  );

  id_multicycle_fsm u_multicycle_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_new_i       (instr_new_i),
    .ctrl_i            (ctrl),
    .branch_decision_i (branch_decision_i),
    .ex_valid_i        (ex_valid_i),
    .lsu_valid_i       (lsu_valid_i),
    .lsu_load_err_i    (lsu_load_err_i),
    .executing_o       (executing),
    .rf_we_o           (regfile_we),
    .id_ready_o        (id_ready_o),
    .pc_set_o          (pc_set_o),
    .instr_ret_o       (instr_ret_o)
  );

  assign illegal_insn_o = ctrl.illegal;

endmodule

// ==== src/id_multicycle_fsm.sv ====
////////////////////////////////////////
// Multicycle control and retirement
////////////////////////////////////////

`timescale 1ns/1ns

module id_multicycle_fsm (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              instr_new_i,
  input  id_pkg::dec_ctrl_t ctrl_i,
  input  logic              branch_decision_i,
  input  logic              ex_valid_i,
  input  logic              lsu_valid_i,
  input  logic              lsu_load_err_i,
  output logic              executing_o,
  output logic              rf_we_o,
  output logic              id_ready_o,
  output logic              pc_set_o,
  output logic              instr_ret_o
);

  id_pkg::id_fsm_e state_q, state_d;
  logic            done_q, done_d;
  logic            branch_set_q, branch_set_d;
  logic            jump_set;
  logic            multicycle;
  logic            stall;
  logic            complete;

  assign multicycle = ctrl_i.data_req | ctrl_i.branch | ctrl_i.jump;

  // A new instruction, or a multicycle one not yet finished
  assign executing_o = instr_new_i | (multicycle & ~done_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= id_pkg::IDLE;
      done_q       <= 1'b1;
      branch_set_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      done_q       <= done_d;
      branch_set_q <= branch_set_d;
    end
  end

  always_comb begin
    state_d      = state_q;
    done_d       = done_q;
    branch_set_d = 1'b0;
    jump_set     = 1'b0;
    stall        = 1'b0;
    complete     = 1'b0;
    instr_ret_o  = 1'b0;

    case (state_q)
      id_pkg::IDLE: begin
        // Only a new instruction is classified here
        if (instr_new_i) begin
          if (ctrl_i.data_req) begin
            state_d = id_pkg::WAIT_MULTICYCLE;
            done_d  = 1'b0;
            stall   = 1'b1;
          end else if (ctrl_i.branch) begin
            state_d      = branch_decision_i ? id_pkg::WAIT_MULTICYCLE : id_pkg::IDLE;
            done_d       = ~branch_decision_i;
            stall        = branch_decision_i;
            branch_set_d = branch_decision_i;
            instr_ret_o  = ~branch_decision_i;
          end else if (ctrl_i.jump) begin
            state_d  = id_pkg::WAIT_MULTICYCLE;
            done_d   = 1'b0;
            stall    = 1'b1;
            jump_set = 1'b1;
          end else begin
            done_d      = 1'b1;
            instr_ret_o = ~ctrl_i.illegal;
          end
        end
      end

      id_pkg::WAIT_MULTICYCLE: begin
        // The redirect cycle of a taken branch is never its last one
        if (ctrl_i.data_req ? lsu_valid_i : (ex_valid_i & ~branch_set_q)) begin
          state_d     = id_pkg::IDLE;
          done_d      = 1'b1;
          complete    = 1'b1;
          instr_ret_o = 1'b1;
        end else begin
          stall = 1'b1;
        end
      end

      default: state_d = id_pkg::IDLE;
    endcase
  end

  ////////////////////////////////////////
  // Write enable and redirect
  always_comb begin
    if (!executing_o || ctrl_i.illegal) begin
      rf_we_o = 1'b0;
    end else if (ctrl_i.data_req || ctrl_i.jump) begin
      // Written back only when the result arrives
      rf_we_o = complete & ctrl_i.rf_we & ~(ctrl_i.data_req & lsu_load_err_i);
    end else begin
      rf_we_o = ctrl_i.rf_we;
    end
  end

  assign id_ready_o = ~stall;
  assign pc_set_o   = branch_set_q | jump_set;

endmodule

// ==== src/id_operand_mux.sv ====
////////////////////////////////////////
// Operand selection for EX and LSU
////////////////////////////////////////

`timescale 1ns/1ns

module id_operand_mux (
  input  id_pkg::dec_ctrl_t ctrl_i,
  input  id_pkg::imm_set_t  imm_i,
  input  id_pkg::word_t     pc_i,
  input  id_pkg::word_t     rdata_a_i,
  input  id_pkg::word_t     rdata_b_i,
  input  logic              executing_i,
  output id_pkg::ex_req_t   ex_req_o,
  output id_pkg::lsu_req_t  lsu_req_o
);

  id_pkg::word_t imm_b;
  id_pkg::word_t operand_a;

  // Immediate for operand B
  always_comb begin
    case (ctrl_i.imm_b_sel)
      id_pkg::IMM_I:    imm_b = imm_i.i;
      id_pkg::IMM_S:    imm_b = imm_i.s;
      id_pkg::IMM_B:    imm_b = imm_i.b;
      id_pkg::IMM_U:    imm_b = imm_i.u;
      id_pkg::IMM_J:    imm_b = imm_i.j;
      id_pkg::IMM_INCR: imm_b = id_pkg::PC_INCR;
      default:          imm_b = '0;
    endcase
  end

  always_comb begin
    case (ctrl_i.op_a_sel)
      id_pkg::OP_A_REG: operand_a = rdata_a_i;
      id_pkg::OP_A_PC:  operand_a = pc_i;
      default:          operand_a = '0;
    endcase
  end

  always_comb begin
    ex_req_o.alu_op    = ctrl_i.alu_op;
    ex_req_o.operand_a = operand_a;
    ex_req_o.operand_b = (ctrl_i.op_b_sel == id_pkg::OP_B_IMM) ? imm_b : rdata_b_i;
  end

  // Request only while the instruction is still executing
  always_comb begin
    lsu_req_o.req      = ctrl_i.data_req & executing_i;
    lsu_req_o.we       = ctrl_i.data_we;
    lsu_req_o.size     = ctrl_i.data_size;
    lsu_req_o.sign_ext = ctrl_i.data_sign_ext;
    lsu_req_o.wdata    = rdata_b_i;
  end

endmodule

// ==== src/id_register_file.sv ====
////////////////////////////////////////
// Integer register file
////////////////////////////////////////

`timescale 1ns/1ns

module id_register_file (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  id_pkg::reg_addr_t raddr_a_i,
  output id_pkg::word_t     rdata_a_o,
  input  id_pkg::reg_addr_t raddr_b_i,
  output id_pkg::word_t     rdata_b_o,
  input  id_pkg::reg_addr_t waddr_i,
  input  id_pkg::word_t     wdata_i,
  input  logic              we_i
);

  // x1 to x31, x0 has no storage
  id_pkg::word_t regs_q [1:31];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// ==== src/id_decoder.sv ====
////////////////////////////////////////
// RV32I instruction decoder
////////////////////////////////////////

`timescale 1ns/1ns

module id_decoder (
  input  id_pkg::word_t     instr_i,
  output id_pkg::dec_ctrl_t ctrl_o,
  output id_pkg::imm_set_t  imm_o
);

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  id_pkg::reg_addr_t rs1;
  id_pkg::reg_addr_t rs2;
  id_pkg::reg_addr_t rd;

  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];
  assign funct7 = instr_i[31:25];

  ////////////////////////////////////////
  // Immediates
  always_comb begin
    imm_o.i = {{20{instr_i[31]}}, instr_i[31:20]};
    imm_o.s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    imm_o.b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
               instr_i[11:8], 1'b0};
    imm_o.u = {instr_i[31:12], 12'b0};
    imm_o.j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
  end

  ////////////////////////////////////////
  // Control fields
  always_comb begin
    ctrl_o.rf_we         = 1'b0;
    ctrl_o.rf_wd_sel     = id_pkg::RF_WD_EX;
    ctrl_o.raddr_a       = rs1;
    ctrl_o.raddr_b       = rs2;
    ctrl_o.waddr         = rd;
    ctrl_o.alu_op        = id_pkg::ALU_ADD;
    ctrl_o.op_a_sel      = id_pkg::OP_A_REG;
    ctrl_o.op_b_sel      = id_pkg::OP_B_IMM;
    ctrl_o.imm_b_sel     = id_pkg::IMM_I;
    ctrl_o.data_req      = 1'b0;
    ctrl_o.data_we       = 1'b0;
    ctrl_o.data_size     = funct3[1:0];
    ctrl_o.data_sign_ext = ~funct3[2];
    ctrl_o.branch        = 1'b0;
    ctrl_o.jump          = 1'b0;
    ctrl_o.illegal       = 1'b0;

    case (opcode)
      id_pkg::OPC_OP_IMM: begin
        ctrl_o.rf_we = 1'b1;
        case (funct3)
          3'b000: ctrl_o.alu_op = id_pkg::ALU_ADD;
          3'b010: ctrl_o.alu_op = id_pkg::ALU_SLT;
          3'b011: ctrl_o.alu_op = id_pkg::ALU_SLTU;
          3'b100: ctrl_o.alu_op = id_pkg::ALU_XOR;
          3'b110: ctrl_o.alu_op = id_pkg::ALU_OR;
          3'b111: ctrl_o.alu_op = id_pkg::ALU_AND;
          3'b001: begin
            ctrl_o.alu_op  = id_pkg::ALU_SLL;
            ctrl_o.illegal = (funct7 != 7'b0000000);
          end
          default: begin
            // funct3 101, shift right with shamt
            ctrl_o.alu_op  = funct7[5] ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
            ctrl_o.illegal = ({funct7[6], funct7[4:0]} != 6'b0);
          end
        endcase
      end

      id_pkg::OPC_OP: begin
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_b_sel = id_pkg::OP_B_REG;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: ctrl_o.alu_op = id_pkg::ALU_ADD;
          {7'b0100000, 3'b000}: ctrl_o.alu_op = id_pkg::ALU_SUB;
          {7'b0000000, 3'b001}: ctrl_o.alu_op = id_pkg::ALU_SLL;
          {7'b0000000, 3'b010}: ctrl_o.alu_op = id_pkg::ALU_SLT;
          {7'b0000000, 3'b011}: ctrl_o.alu_op = id_pkg::ALU_SLTU;
          {7'b0000000, 3'b100}: ctrl_o.alu_op = id_pkg::ALU_XOR;
          {7'b0000000, 3'b101}: ctrl_o.alu_op = id_pkg::ALU_SRL;
          {7'b0100000, 3'b101}: ctrl_o.alu_op = id_pkg::ALU_SRA;
          {7'b0000000, 3'b110}: ctrl_o.alu_op = id_pkg::ALU_OR;
          {7'b0000000, 3'b111}: ctrl_o.alu_op = id_pkg::ALU_AND;
          default:              ctrl_o.illegal = 1'b1;
        endcase
      end

      id_pkg::OPC_LUI: begin
        ctrl_o.rf_we     = 1'b1;
        ctrl_o.op_a_sel  = id_pkg::OP_A_ZERO;
        ctrl_o.imm_b_sel = id_pkg::IMM_U;
      end

      id_pkg::OPC_AUIPC: begin
        ctrl_o.rf_we     = 1'b1;
        ctrl_o.op_a_sel  = id_pkg::OP_A_PC;
        ctrl_o.imm_b_sel = id_pkg::IMM_U;
      end

      id_pkg::OPC_LOAD: begin
        ctrl_o.rf_we     = 1'b1;
        ctrl_o.rf_wd_sel = id_pkg::RF_WD_LSU;
        ctrl_o.data_req  = 1'b1;
        // No LWU and no 64-bit access
        ctrl_o.illegal   = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end

      id_pkg::OPC_STORE: begin
        ctrl_o.data_req  = 1'b1;
        ctrl_o.data_we   = 1'b1;
        ctrl_o.imm_b_sel = id_pkg::IMM_S;
        ctrl_o.illegal   = funct3[2] || (funct3[1:0] == 2'b11);
      end

      id_pkg::OPC_BRANCH: begin
        ctrl_o.branch    = 1'b1;
        ctrl_o.op_b_sel  = id_pkg::OP_B_REG;
        ctrl_o.imm_b_sel = id_pkg::IMM_B;
        case (funct3)
          3'b000:  ctrl_o.alu_op = id_pkg::ALU_EQ;
          3'b001:  ctrl_o.alu_op = id_pkg::ALU_NE;
          3'b100:  ctrl_o.alu_op = id_pkg::ALU_LT;
          3'b101:  ctrl_o.alu_op = id_pkg::ALU_GE;
          3'b110:  ctrl_o.alu_op = id_pkg::ALU_LTU;
          3'b111:  ctrl_o.alu_op = id_pkg::ALU_GEU;
          default: ctrl_o.illegal = 1'b1;
        endcase
      end

      id_pkg::OPC_JAL: begin
        // EX computes the link value PC + 4
        ctrl_o.jump      = 1'b1;
        ctrl_o.rf_we     = 1'b1;
        ctrl_o.op_a_sel  = id_pkg::OP_A_PC;
        ctrl_o.imm_b_sel = id_pkg::IMM_INCR;
      end

      default: ctrl_o.illegal = 1'b1;
    endcase

    // Illegal encodings have no side effects
    if (ctrl_o.illegal) begin
      ctrl_o.rf_we    = 1'b0;
      ctrl_o.data_req = 1'b0;
      ctrl_o.data_we  = 1'b0;
      ctrl_o.branch   = 1'b0;
      ctrl_o.jump     = 1'b0;
    end
  end

endmodule

// ==== src/id_pkg.sv ====
////////////////////////////////////////
// Decode stage shared definitions
////////////////////////////////////////

package id_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [1:0]  mem_size_t;

  ////////////////////////////////////////
  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_JAL    = 7'h6f;

  // Link increment for JAL
  localparam word_t PC_INCR = 32'd4;

  ////////////////////////////////////////
  // Control encodings
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic {OP_B_REG, OP_B_IMM} op_b_sel_e;
  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_INCR} imm_b_sel_e;
  typedef enum logic {RF_WD_EX, RF_WD_LSU} rf_wd_sel_e;

  // Multicycle tracking in the FSM
  typedef enum logic {IDLE, WAIT_MULTICYCLE} id_fsm_e;

  ////////////////////////////////////////
  // Bundles
  typedef struct packed {
    word_t instr;
    word_t pc;
  } fetch_t;

  typedef struct packed {
    logic       rf_we;
    rf_wd_sel_e rf_wd_sel;
    reg_addr_t  raddr_a;
    reg_addr_t  raddr_b;
    reg_addr_t  waddr;
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_b_sel_e imm_b_sel;
    logic       data_req;
    logic       data_we;
    mem_size_t  data_size;
    logic       data_sign_ext;
    logic       branch;
    logic       jump;
    logic       illegal;
  } dec_ctrl_t;

  // All immediates, sign extended
  typedef struct packed {
    word_t i;
    word_t s;
    word_t b;
    word_t u;
    word_t j;
  } imm_set_t;

  typedef struct packed {
    alu_op_e alu_op;
    word_t   operand_a;
    word_t   operand_b;
  } ex_req_t;

  typedef struct packed {
    logic      req;
    logic      we;
    mem_size_t size;
    logic      sign_ext;
    word_t     wdata;
  } lsu_req_t;

endpackage
